//--- hw/fifo_cfg_pkg.sv
package fifo_cfg_pkg;

   // write side carries whole words
   localparam int W_DATA_W = 32;

   // read side hands out single bytes
   localparam int R_DATA_W = 8;

   // bytes packed into one write word
   localparam int RATIO = W_DATA_W / R_DATA_W;

   // selects one byte inside a word
   localparam int LANE_W = $clog2(RATIO);

   // narrow (byte) address width
   localparam int ADDR_W = 4;

   // wide (word) address width
   localparam int WORD_ADDR_W = ADDR_W - LANE_W;

   // capacity counted in bytes
   localparam int FIFO_BYTES = 2 ** ADDR_W;

   // RAM depth counted in words
   localparam int FIFO_WORDS = FIFO_BYTES / RATIO;

   // pointers carry one extra wrap bit over the address
   localparam int W_PTR_W = WORD_ADDR_W + 1;
   localparam int R_PTR_W = ADDR_W + 1;

endpackage

//--- hw/fifo_types_pkg.sv
package fifo_types_pkg;

   // one datum on the read side
   typedef logic [fifo_cfg_pkg::R_DATA_W-1:0] byte_t;

   // fill level in bytes, one bit wider than the byte address
   typedef logic [fifo_cfg_pkg::ADDR_W:0] level_t;

   // a stored RAM word
   // the write side fills it as one word, the read side picks a byte lane
   // lane 0 is the least significant byte
   typedef union packed {
      logic [fifo_cfg_pkg::W_DATA_W-1:0] word;
      byte_t [fifo_cfg_pkg::RATIO-1:0] lanes;
   } mem_word_u;

endpackage

//--- hw/fifo_mem_if.sv
`timescale 1ns/1ps

interface fifo_mem_if;

   // write port, w_clk_i domain
   logic w_en;
   logic [fifo_cfg_pkg::WORD_ADDR_W-1:0] w_addr;
   fifo_types_pkg::mem_word_u w_data;

   // read port, r_clk_i domain
   // data shows up one r_clk_i edge after r_en
   logic r_en;
   logic [fifo_cfg_pkg::WORD_ADDR_W-1:0] r_addr;
   fifo_types_pkg::mem_word_u r_data;

   // FIFO control side
   modport ctrl (
      output w_en,
      output w_addr,
      output w_data,
      output r_en,
      output r_addr,
      input  r_data
   );

   // memory side
   modport ram (
      input  w_en,
      input  w_addr,
      input  w_data,
      input  r_en,
      input  r_addr,
      output r_data
   );

endinterface

//--- hw/gray_ptr_counter.sv
`timescale 1ns/1ps

module gray_ptr_counter #(
   parameter int PTR_W = 3
) (
   input  logic             clk_i,
   input  logic             rst_n_i,
   input  logic             en_i,
   output logic [PTR_W-1:0] gray_o,
   output logic [PTR_W-1:0] bin_o
);

   logic [PTR_W-1:0] bin_q;
   logic [PTR_W-1:0] bin_next;
   logic [PTR_W-1:0] gray_q;

   assign bin_next = bin_q + PTR_W'(1);

   // gray value is registered so the crossing sees a clean flop output
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         bin_q  <= '0;
         gray_q <= '0;
      end else if (en_i) begin
         bin_q  <= bin_next;
         gray_q <= bin_next ^ (bin_next >> 1);
      end
   end

   assign gray_o = gray_q;
   assign bin_o  = bin_q;

   // the synchronizer on the far side relies on single bit steps
   a_gray_one_step : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      $countones(gray_o ^ $past(gray_o)) <= 1
   );

endmodule

//--- hw/ptr_sync.sv
`timescale 1ns/1ps

module ptr_sync #(
   parameter int PTR_W = 3
) (
   input  logic             clk_i,
   input  logic             rst_n_i,
   input  logic [PTR_W-1:0] gray_i,
   output logic [PTR_W-1:0] gray_o,
   output logic [PTR_W-1:0] bin_o
);

   logic [PTR_W-1:0] meta_q;
   logic [PTR_W-1:0] sync_q;
   logic [PTR_W-1:0] bin_c;

   // two stages into the destination clock
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         meta_q <= '0;
         sync_q <= '0;
      end else begin
         meta_q <= gray_i;
         sync_q <= meta_q;
      end
   end

   // gray to binary, each bit is the xor of all higher gray bits
   always_comb begin
      for (int i = 0; i < PTR_W; i++) begin
         bin_c[i] = ^(sync_q >> i);
      end
   end

   assign gray_o = sync_q;
   assign bin_o  = bin_c;

endmodule

//--- hw/asym_converter.sv
`timescale 1ns/1ps

module asym_converter (
   input  logic                                    w_clk_i,
   input  logic                                    r_clk_i,
   input  logic                                    rst_n_i,
   input  logic                                    w_en_i,
   input  logic [fifo_cfg_pkg::WORD_ADDR_W-1:0]    w_ptr_i,
   input  logic [fifo_cfg_pkg::W_DATA_W-1:0]       w_data_i,
   input  logic                                    r_en_i,
   input  logic [fifo_cfg_pkg::ADDR_W-1:0]         r_ptr_i,
   output fifo_types_pkg::byte_t                   r_data_o,
   fifo_mem_if.ctrl                                mem
);

   fifo_types_pkg::mem_word_u wr_word;
   fifo_types_pkg::mem_word_u rd_word;
   logic [fifo_cfg_pkg::LANE_W-1:0] r_lane_q;
   logic r_valid_q;

   // write side stores one whole word per pointer step
   always_comb begin
      wr_word.word = w_data_i;
   end

   assign mem.w_en   = w_en_i;
   assign mem.w_addr = w_ptr_i;
   assign mem.w_data = wr_word;

   // byte pointer splits into word address and lane
   assign mem.r_en   = r_en_i;
   assign mem.r_addr = r_ptr_i[fifo_cfg_pkg::ADDR_W-1:fifo_cfg_pkg::LANE_W];

   // lane follows the RAM read by one edge, same as the data
   always_ff @(posedge r_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         r_lane_q  <= '0;
         r_valid_q <= 1'b0;
      end else if (r_en_i) begin
         r_lane_q  <= r_ptr_i[fifo_cfg_pkg::LANE_W-1:0];
         r_valid_q <= 1'b1;
      end
   end

   assign rd_word = mem.r_data;

   // RAM output is unknown until the first read, show zero until then
   assign r_data_o = r_valid_q ? rd_word.lanes[r_lane_q] : '0;

   a_no_write_in_reset : assert property (
      @(posedge w_clk_i)
      !rst_n_i |-> !$rose(mem.w_en)
   );

endmodule

//--- hw/dp_ram.sv
`timescale 1ns/1ps

module dp_ram (
   input  logic    w_clk_i,
   input  logic    r_clk_i,
   fifo_mem_if.ram mem
);

   fifo_types_pkg::mem_word_u ram_q [fifo_cfg_pkg::FIFO_WORDS];
   fifo_types_pkg::mem_word_u rd_q;

   always_ff @(posedge w_clk_i) begin
      if (mem.w_en) begin
         ram_q[mem.w_addr] <= mem.w_data;
      end
   end

   // registered read, holds the last word between reads
   always_ff @(posedge r_clk_i) begin
      if (mem.r_en) begin
         rd_q <= ram_q[mem.r_addr];
      end
   end

   assign mem.r_data = rd_q;

endmodule

//--- hw/afifo_core.sv
`timescale 1ns/1ps

module afifo_core (
   input  logic                              w_clk_i,
   input  logic                              r_clk_i,
   input  logic                              rst_n_i,
   input  logic                              w_en_i,
   input  logic [fifo_cfg_pkg::W_DATA_W-1:0] w_data_i,
   input  logic                              r_en_i,
   output fifo_types_pkg::byte_t             r_data_o,
   output logic                              w_full_o,
   output logic                              w_empty_o,
   output fifo_types_pkg::level_t            w_level_o,
   output logic                              r_full_o,
   output logic                              r_empty_o,
   output fifo_types_pkg::level_t            r_level_o,
   fifo_mem_if.ctrl                          mem
);

   // word pointer, local and as seen from the read side
   logic [fifo_cfg_pkg::W_PTR_W-1:0] w_ptr_gray;
   logic [fifo_cfg_pkg::W_PTR_W-1:0] w_ptr_bin;
   logic [fifo_cfg_pkg::W_PTR_W-1:0] r_wptr_gray;
   logic [fifo_cfg_pkg::W_PTR_W-1:0] r_wptr_bin;

   // byte pointer, local and as seen from the write side
   logic [fifo_cfg_pkg::R_PTR_W-1:0] r_ptr_gray;
   logic [fifo_cfg_pkg::R_PTR_W-1:0] r_ptr_bin;
   logic [fifo_cfg_pkg::R_PTR_W-1:0] w_rptr_gray;
   logic [fifo_cfg_pkg::R_PTR_W-1:0] w_rptr_bin;

   // word pointers scaled to byte units
   logic [fifo_cfg_pkg::R_PTR_W-1:0] w_wptr_bytes;
   logic [fifo_cfg_pkg::R_PTR_W-1:0] r_wptr_bytes;

   fifo_types_pkg::level_t w_level;
   fifo_types_pkg::level_t r_level;

   logic w_en_acc;
   logic r_en_acc;

   assign w_en_acc = w_en_i & ~w_full_o;
   assign r_en_acc = r_en_i & ~r_empty_o;

   gray_ptr_counter #(
      .PTR_W (fifo_cfg_pkg::W_PTR_W)
   ) u_w_ptr (
      .clk_i   (w_clk_i),
      .rst_n_i (rst_n_i),
      .en_i    (w_en_acc),
      .gray_o  (w_ptr_gray),
      .bin_o   (w_ptr_bin)
   );

   gray_ptr_counter #(
      .PTR_W (fifo_cfg_pkg::R_PTR_W)
   ) u_r_ptr (
      .clk_i   (r_clk_i),
      .rst_n_i (rst_n_i),
      .en_i    (r_en_acc),
      .gray_o  (r_ptr_gray),
      .bin_o   (r_ptr_bin)
   );

   // write pointer into the read domain
   ptr_sync #(
      .PTR_W (fifo_cfg_pkg::W_PTR_W)
   ) u_w2r_sync (
      .clk_i   (r_clk_i),
      .rst_n_i (rst_n_i),
      .gray_i  (w_ptr_gray),
      .gray_o  (r_wptr_gray),
      .bin_o   (r_wptr_bin)
   );

   // read pointer into the write domain
   ptr_sync #(
      .PTR_W (fifo_cfg_pkg::R_PTR_W)
   ) u_r2w_sync (
      .clk_i   (w_clk_i),
      .rst_n_i (rst_n_i),
      .gray_i  (r_ptr_gray),
      .gray_o  (w_rptr_gray),
      .bin_o   (w_rptr_bin)
   );

   assign w_wptr_bytes = {w_ptr_bin, {fifo_cfg_pkg::LANE_W{1'b0}}};
   assign r_wptr_bytes = {r_wptr_bin, {fifo_cfg_pkg::LANE_W{1'b0}}};

   // write domain, one write moves the level by a whole word
   assign w_level   = w_wptr_bytes - w_rptr_bin;
   assign w_level_o = w_level;
   assign w_empty_o = w_level < fifo_types_pkg::level_t'(fifo_cfg_pkg::RATIO);
   assign w_full_o  = w_level >
      fifo_types_pkg::level_t'(fifo_cfg_pkg::FIFO_BYTES - fifo_cfg_pkg::RATIO);

   // read domain, one read moves the level by a byte
   assign r_level   = r_wptr_bytes - r_ptr_bin;
   assign r_level_o = r_level;
   assign r_empty_o = r_level == '0;
   assign r_full_o  = r_level == fifo_types_pkg::level_t'(fifo_cfg_pkg::FIFO_BYTES);

   asym_converter u_conv (
      .w_clk_i  (w_clk_i),
      .r_clk_i  (r_clk_i),
      .rst_n_i  (rst_n_i),
      .w_en_i   (w_en_acc),
      .w_ptr_i  (w_ptr_bin[fifo_cfg_pkg::WORD_ADDR_W-1:0]),
      .w_data_i (w_data_i),
      .r_en_i   (r_en_acc),
      .r_ptr_i  (r_ptr_bin[fifo_cfg_pkg::ADDR_W-1:0]),
      .r_data_o (r_data_o),
      .mem      (mem)
   );

   // while full no write lands, so the level can only fall
   a_no_write_when_full : assert property (
      @(posedge w_clk_i) disable iff (!rst_n_i)
      w_full_o |=> w_level <= $past(w_level)
   );

   // synchronized pointers still step by one bit at most
   a_w2r_one_step : assert property (
      @(posedge r_clk_i) disable iff (!rst_n_i)
      $countones(r_wptr_gray ^ $past(r_wptr_gray)) <= 1
   );

   a_r2w_one_step : assert property (
      @(posedge w_clk_i) disable iff (!rst_n_i)
      $countones(w_rptr_gray ^ $past(w_rptr_gray)) <= 1
   );

endmodule

//--- hw/afifo_top.sv
`timescale 1ns/1ps

module afifo_top (
   input  logic                              w_clk_i,
   input  logic                              r_clk_i,
   input  logic                              rst_n_i,
   // write side
   input  logic                              w_en_i,
   input  logic [fifo_cfg_pkg::W_DATA_W-1:0] w_data_i,
   output logic                              w_full_o,
   output logic                              w_empty_o,
   output fifo_types_pkg::level_t            w_level_o,
   // read side
   input  logic                              r_en_i,
   output fifo_types_pkg::byte_t             r_data_o,
   output logic                              r_full_o,
   output logic                              r_empty_o,
   output fifo_types_pkg::level_t            r_level_o
);

   fifo_mem_if u_mem_if ();

   afifo_core u_core (
      .w_clk_i   (w_clk_i),
      .r_clk_i   (r_clk_i),
      .rst_n_i   (rst_n_i),
      .w_en_i    (w_en_i),
      .w_data_i  (w_data_i),
      .r_en_i    (r_en_i),
      .r_data_o  (r_data_o),
      .w_full_o  (w_full_o),
      .w_empty_o (w_empty_o),
      .w_level_o (w_level_o),
      .r_full_o  (r_full_o),
      .r_empty_o (r_empty_o),
      .r_level_o (r_level_o),
      .mem       (u_mem_if)
   );

   // word storage, 4 words of 4 bytes
   dp_ram u_ram (
      .w_clk_i (w_clk_i),
      .r_clk_i (r_clk_i),
      .mem     (u_mem_if)
   );

endmodule

//--- bench/afifo_tb_checks.svh
`ifndef AFIFO_TB_CHECKS_SVH
`define AFIFO_TB_CHECKS_SVH

// mismatches seen over the whole run
int err_count = 0;

// galois LFSR state, taps for x^16 + x^14 + x^13 + x^11 + 1
logic [15:0] lfsr_q = 16'd49784;

task automatic check_byte(input string name, input fifo_types_pkg::byte_t got,
                          input fifo_types_pkg::byte_t exp);
   if (got !== exp) begin
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      err_count++;
   end
endtask

task automatic check_level(input string name, input fifo_types_pkg::level_t got,
                           input fifo_types_pkg::level_t exp);
   if (got !== exp) begin
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      err_count++;
   end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
   if (got !== exp) begin
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      err_count++;
   end
endtask

// one step per bit taken
function automatic logic rand_bit();
   logic b;
   b = lfsr_q[0];
   lfsr_q = lfsr_q >> 1;
   if (b) lfsr_q = lfsr_q ^ 16'hB400;
   return b;
endfunction

function automatic logic [31:0] rand_word();
   logic [31:0] w;
   for (int i = 0; i < 32; i++) w[i] = rand_bit();
   return w;
endfunction

`endif

//--- bench/afifo_tb.sv
`timescale 1ns/1ps

module afifo_tb;

   logic w_clk_i;
   logic r_clk_i;
   logic rst_n_i;
   logic w_en_i;
   logic [fifo_cfg_pkg::W_DATA_W-1:0] w_data_i;
   logic r_en_i;
   fifo_types_pkg::byte_t r_data_o;
   logic w_full_o;
   logic w_empty_o;
   fifo_types_pkg::level_t w_level_o;
   logic r_full_o;
   logic r_empty_o;
   fifo_types_pkg::level_t r_level_o;

   `include "afifo_tb_checks.svh"

   // expected bytes in FIFO order
   fifo_types_pkg::byte_t model_q[$];
   fifo_types_pkg::byte_t last_read = '0;
   logic [63:0] cmd_q[$];
   logic [31:0] arg_q[$];
   int wd_cycles = 0;
   logic wd_armed = 1'b0;
   int pass_tests = 0;
   int fail_tests = 0;

   afifo_top i_dut (.*);

   initial w_clk_i = 1'b0;
   initial r_clk_i = 1'b0;
   always #2 w_clk_i = ~w_clk_i;

   // read clock lags by 1.3 ns
   always begin
      #1.3;
      forever #2 r_clk_i = ~r_clk_i;
   end

   task automatic load_stim();
      int fd;
      string line;
      logic [63:0] cmd;
      logic [31:0] arg;
      fd = $fopen("bench/afifo_stim.txt", "r");
      if (fd == 0) begin
         $display("could not open the stimulus file");
         err_count++;
      end else begin
         while ($fgets(line, fd)) begin
            if (line.len() > 1 && line[0] != "#") begin
               arg = '0;
               void'($sscanf(line, "%s %h", cmd, arg));
               cmd_q.push_back(cmd);
               arg_q.push_back(arg);
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic push_word(input logic [31:0] word);
      for (int i = 0; i < fifo_cfg_pkg::RATIO; i++) model_q.push_back(word[8*i +: 8]);
   endtask

   task automatic write_word(input logic [31:0] word);
      @(posedge w_clk_i);
      #0.5;
      w_en_i = 1'b1;
      w_data_i = word;
      // full only moves on w_clk_i edges, so this is the flag the next edge sees
      if (!w_full_o) push_word(word);
      @(posedge w_clk_i);
      #0.5;
      w_en_i = 1'b0;
   endtask

   task automatic read_expect(input fifo_types_pkg::byte_t exp);
      int waited;
      waited = 0;
      @(posedge r_clk_i);
      #0.5;
      while (r_empty_o && waited < 20) begin
         @(posedge r_clk_i);
         #0.5;
         waited++;
      end
      if (r_empty_o) begin
         $display("read gave up, r_empty_o stayed high for 20 cycles");
         err_count++;
      end else begin
         r_en_i = 1'b1;
         @(posedge r_clk_i);
         #0.5;
         r_en_i = 1'b0;
         check_byte("r_data_o", r_data_o, exp);
         last_read = exp;
         if (model_q.size() > 0) void'(model_q.pop_front());
      end
   endtask

   task automatic empty_read();
      @(posedge r_clk_i);
      #0.5;
      check_flag("r_empty_o", r_empty_o, 1'b1);
      r_en_i = 1'b1;
      @(posedge r_clk_i);
      #0.5;
      r_en_i = 1'b0;
      @(posedge r_clk_i);
      #0.5;
      check_byte("r_data_o", r_data_o, last_read);
   endtask

   task automatic settle();
      fifo_types_pkg::level_t held;
      repeat (6) @(posedge w_clk_i);
      repeat (6) @(posedge r_clk_i);
      #0.5;
      held = fifo_types_pkg::level_t'(model_q.size());
      check_level("w_level_o", w_level_o, held);
      check_level("r_level_o", r_level_o, held);
      // no room for a whole word once fewer than 4 bytes are free
      check_flag("w_full_o", w_full_o,
                 held > fifo_cfg_pkg::FIFO_BYTES - fifo_cfg_pkg::RATIO);
      check_flag("r_full_o", r_full_o, held == fifo_cfg_pkg::FIFO_BYTES);
      check_flag("r_empty_o", r_empty_o, held == 0);
   endtask

   task automatic reset_check();
      check_flag("w_empty_o", w_empty_o, 1'b1);
      check_flag("r_empty_o", r_empty_o, 1'b1);
      check_flag("w_full_o", w_full_o, 1'b0);
      check_flag("r_full_o", r_full_o, 1'b0);
      check_level("w_level_o", w_level_o, '0);
      check_level("r_level_o", r_level_o, '0);
      check_byte("r_data_o", r_data_o, '0);
   endtask

   task automatic burst(input int n);
      logic pending;
      fifo_types_pkg::byte_t exp;
      pending = 1'b0;
      fork
         begin
            for (int i = 0; i < n; i++) begin
               @(posedge w_clk_i);
               #0.5;
               w_en_i = rand_bit();
               w_data_i = rand_word();
               if (w_en_i && !w_full_o) push_word(w_data_i);
            end
            @(posedge w_clk_i);
            #0.5;
            w_en_i = 1'b0;
         end
         begin
            for (int i = 0; i <= n; i++) begin
               @(posedge r_clk_i);
               #0.5;
               if (pending && model_q.size() == 0) begin
                  $display("read accepted with nothing written");
                  err_count++;
               end else if (pending) begin
                  exp = model_q.pop_front();
                  check_byte("r_data_o", r_data_o, exp);
                  last_read = exp;
               end
               if (i < n) begin
                  r_en_i = rand_bit();
                  pending = r_en_i && !r_empty_o;
               end else begin
                  r_en_i = 1'b0;
                  pending = 1'b0;
               end
            end
         end
      join
   endtask

   initial begin
      wait (wd_armed);
      repeat (wd_cycles) @(posedge w_clk_i);
      $display("watchdog expired after %0d cycles, the run is stuck", wd_cycles);
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial begin
      int errs_before;
      rst_n_i = 1'b0;
      w_en_i = 1'b0;
      w_data_i = '0;
      r_en_i = 1'b0;
      load_stim();
      wd_cycles = cmd_q.size() * 40;
      // without commands the run ends on its own after reset
      if (cmd_q.size() > 0) wd_armed = 1'b1;
      repeat (8) @(posedge w_clk_i);
      #0.5;
      rst_n_i = 1'b1;
      foreach (cmd_q[k]) begin
         errs_before = err_count;
         case (cmd_q[k])
            "reset": reset_check();
            "write": write_word(arg_q[k]);
            "read": read_expect(arg_q[k][7:0]);
            "eread": empty_read();
            "wfull": check_flag("w_full_o", w_full_o, arg_q[k][0]);
            "settle": settle();
            "count": check_level("model level", fifo_types_pkg::level_t'(model_q.size()),
                                 fifo_types_pkg::level_t'(arg_q[k]));
            "burst": burst(int'(arg_q[k]));
            "drain": begin
               while (model_q.size() > 0) read_expect(model_q[0]);
            end
            default: begin
               $display("unknown command in the stimulus file");
               err_count++;
            end
         endcase
         if (err_count == errs_before) pass_tests++;
         else fail_tests++;
         $display("test %0d %0s %0s", k, cmd_q[k], (err_count == errs_before) ? "ok" : "bad");
      end
      $display("tests %0d, passed %0d, failed %0d, errors %0d",
               cmd_q.size(), pass_tests, fail_tests, err_count);
      if (fail_tests == 0 && err_count == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

//--- bench/afifo_stim.txt
# columns: command, then a hex argument (word, expected byte, flag, count or cycles)
# reset eread write read wfull settle count burst drain
reset
eread
write 11223344
read 44
read 33
read 22
read 11
eread
write a0a1a2a3
write b0b1b2b3
write c0c1c2c3
write d0d1d2d3
wfull 1
write e0e1e2e3
settle
count 10
read a3
read a2
drain
settle
eread
burst 50
settle
drain
settle

//--- compile.f
+incdir+bench
hw/fifo_cfg_pkg.sv
hw/fifo_types_pkg.sv
hw/fifo_mem_if.sv
hw/gray_ptr_counter.sv
hw/ptr_sync.sv
hw/asym_converter.sv
hw/dp_ram.sv
hw/afifo_core.sv
hw/afifo_top.sv
bench/afifo_tb.sv
